/* husky_io.f */
+incdir+common
+incdir+testbench
common/husky_pkg.sv
src/usb_reg_bridge.sv
target_io/target_pin_ctrl.sv
target_io/target_ctrl.sv
src/reg_read_mux.sv
src/husky_io_top.sv
testbench/tb_husky_io.sv

/* Bender.yml */
package:
  name: husky_io

export_include_dirs:
  - common

sources:
  - common/husky_pkg.sv
  - src/usb_reg_bridge.sv
  - target_io/target_pin_ctrl.sv
  - target_io/target_ctrl.sv
  - src/reg_read_mux.sv
  - src/husky_io_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_husky_io.sv

/* testbench/tb_husky_io_ref.svh */
`ifndef TB_HUSKY_IO_REF_SVH
`define TB_HUSKY_IO_REF_SVH

// Register model, follows every completed bus write
logic       pwr_off_m;
trig_mask_t mask_m;
logic       mode_and_m;
logic [1:0] pin_m [`HUSKY_NUM_PINS];   // {level, enable}

function automatic void model_reset();
   pwr_off_m  = 1'b0;
   mask_m     = '0;
   mode_and_m = 1'b0;
   for (int n = 0; n < `HUSKY_NUM_PINS; n++) begin
      pin_m[n] = 2'b00;
   end
endfunction

function automatic void model_write(reg_addr_t addr, reg_data_t data);
   if (addr == `HUSKY_REG_PWR) pwr_off_m = data[0];
   if (addr == `HUSKY_REG_TRIG_MASK) mask_m = data[4:0];
   if (addr == `HUSKY_REG_TRIG_MODE) mode_and_m = data[0];
   for (int n = 0; n < `HUSKY_NUM_PINS; n++) begin
      if (addr == reg_addr_t'(`HUSKY_REG_PIN_BASE + n)) pin_m[n] = data[1:0];
   end
endfunction

// Byte the host should see for a read at this address and byte index
function automatic reg_data_t expected_read(reg_addr_t addr, bytecnt_t cnt);
   reg_data_t   rd;
   logic [31:0] ver;
   rd  = '0;
   ver = `HUSKY_VERSION_WORD;
   case (addr)
      `HUSKY_REG_PWR:       rd[0] = pwr_off_m;
      `HUSKY_REG_TRIG_MASK: rd[4:0] = mask_m;
      `HUSKY_REG_TRIG_MODE: rd[0] = mode_and_m;
      `HUSKY_REG_VERSION: begin
         if (cnt < `HUSKY_VERSION_BYTES) rd = 8'(ver >> (8 * cnt));   // LSB first
      end
      default: ;
   endcase
   for (int n = 0; n < `HUSKY_NUM_PINS; n++) begin
      if (addr == reg_addr_t'(`HUSKY_REG_PIN_BASE + n)) rd[1:0] = pin_m[n];
   end
   return rd;
endfunction

function automatic logic [`HUSKY_NUM_PINS-1:0] expected_pin_level();
   logic [`HUSKY_NUM_PINS-1:0] lv;
   for (int n = 0; n < `HUSKY_NUM_PINS; n++) begin
      lv[n] = pin_m[n][1];
   end
   return lv;
endfunction

// Pins only drive while the target has power
function automatic logic [`HUSKY_NUM_PINS-1:0] expected_pin_enable();
   logic [`HUSKY_NUM_PINS-1:0] en;
   for (int n = 0; n < `HUSKY_NUM_PINS; n++) begin
      en[n] = pin_m[n][0] && !pwr_off_m;
   end
   return en;
endfunction

function automatic logic expected_trigger(trig_mask_t inputs);
   trig_mask_t hit;
   hit = inputs & mask_m;
   if (mask_m == '0) return 1'b0;
   if (mode_and_m) return hit == mask_m;   // All selected inputs high
   return |hit;
endfunction

`endif

/* testbench/tb_husky_io.sv */
`default_nettype none
`include "husky_settings.svh"

module tb_husky_io;
   timeunit 1ns;
   timeprecision 1ps;
   import husky_pkg::*;

   localparam int CLK_PERIOD    = 100;
   localparam int ACCESS_CYCLES = 10;   // Address latch, strobe and idle gap
   localparam int NUM_ACCESSES  = 70;   // Bus accesses over all five tests
   localparam int TRIG_ROUNDS   = 8;
   localparam int TRIG_PATTERNS = 3;
   localparam int TRIG_CYCLES   = TRIG_ROUNDS * TRIG_PATTERNS * 6;
   localparam longint TIMEOUT_NS =
      2 * CLK_PERIOD * (NUM_ACCESSES * ACCESS_CYCLES + TRIG_CYCLES);

   logic                        clk_usb;
   logic                        reset;
   reg_addr_t                   usb_addr;
   reg_data_t                   usb_wdata;
   logic                        usb_rdn;
   logic                        usb_wrn;
   logic                        usb_cen;
   logic                        usb_alen;
   logic [3:0]                  target_io;
   logic                        target_nrst;
   reg_data_t                   usb_rdata;
   logic                        usb_data_oe;
   logic [`HUSKY_NUM_PINS-1:0]  pin_val;
   logic [`HUSKY_NUM_PINS-1:0]  pin_oe;
   logic                        power_on;
   logic                        trigger;
   string                       test_name;
   logic                        pins_steady;   // Low while a write may move the pins
   reg_addr_t                   rw_addrs [6];

   `include "tb_husky_io_ref.svh"

   husky_io_top u_husky_io_top (
      .clk_usb            (clk_usb),
      .reset_i            (reset),
      .usb_addr_i         (usb_addr),
      .usb_data_i         (usb_wdata),
      .usb_rdn_i          (usb_rdn),
      .usb_wrn_i          (usb_wrn),
      .usb_cen_i          (usb_cen),
      .usb_alen_i         (usb_alen),
      .target_io_i        (target_io),
      .target_nrst_i      (target_nrst),
      .usb_data_o         (usb_rdata),
      .usb_data_oe_o      (usb_data_oe),
      .target_pin_o       (pin_val),
      .target_pin_oe_o    (pin_oe),
      .target_power_on_o  (power_on),
      .trigger_o          (trigger)
   );

   initial begin
      clk_usb = 1'b0;
      forever #(CLK_PERIOD / 2) clk_usb = ~clk_usb;
   end

   initial begin
      #(TIMEOUT_NS);
      report_failure($sformatf("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS));
   end

   task automatic report_failure(string msg);
      $display("%s", msg);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check_data(string name, reg_data_t exp, reg_data_t act);
      if (act !== exp) begin
         report_failure($sformatf("Error in %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic check_pins(string name, logic [`HUSKY_NUM_PINS-1:0] exp_val,
                             logic [`HUSKY_NUM_PINS-1:0] exp_oe,
                             logic [`HUSKY_NUM_PINS-1:0] act_val,
                             logic [`HUSKY_NUM_PINS-1:0] act_oe);
      if (act_oe !== exp_oe || act_val !== exp_val) begin
         report_failure($sformatf("Error in %s: expected pins %b oe %b, actual pins %b oe %b",
                                  name, exp_val, exp_oe, act_val, act_oe));
      end
   endtask

   task automatic check_power(string name, logic exp, logic act);
      if (act !== exp) begin
         report_failure($sformatf("Error in %s: expected power on %b, actual %b",
                                  name, exp, act));
      end
   endtask

   task automatic check_trigger(string name, logic exp, logic act);
      if (act !== exp) begin
         report_failure($sformatf("Error in %s: expected trigger %b, actual %b",
                                  name, exp, act));
      end
   endtask

   // Pins and power against the model whenever no write is in flight
   always @(negedge clk_usb) begin
      if (pins_steady && !reset) begin
         check_pins(test_name, expected_pin_level(), expected_pin_enable(), pin_val, pin_oe);
         check_power(test_name, !pwr_off_m, power_on);
      end
   end

   task automatic latch_addr(reg_addr_t addr);
      @(posedge clk_usb);
      usb_alen <= 1'b0;
      usb_addr <= addr;
      @(posedge clk_usb);
      usb_alen <= 1'b1;
   endtask

   task automatic write_reg(reg_addr_t addr, reg_data_t data);
      pins_steady = 1'b0;
      latch_addr(addr);
      usb_wdata <= data;
      @(posedge clk_usb);
      usb_cen <= 1'b0;
      usb_wrn <= 1'b0;
      repeat (3) @(posedge clk_usb);
      usb_cen <= 1'b1;
      usb_wrn <= 1'b1;
      repeat (2) @(posedge clk_usb);   // Bridge back in IDLE
      model_write(addr, data);
      pins_steady = 1'b1;
   endtask

   task automatic read_byte(output reg_data_t data);
      @(posedge clk_usb);
      usb_cen <= 1'b0;
      usb_rdn <= 1'b0;
      repeat (3) @(posedge clk_usb);
      @(negedge clk_usb);
      if (usb_data_oe !== 1'b1) report_failure("The DUT did not drive the data bus during a read");
      data = usb_rdata;
      @(posedge clk_usb);
      usb_cen <= 1'b1;
      usb_rdn <= 1'b1;
      repeat (2) @(posedge clk_usb);
   endtask

   task automatic read_reg(reg_addr_t addr, output reg_data_t data);
      latch_addr(addr);
      read_byte(data);
   endtask

   initial begin
      reg_data_t  rd;
      trig_mask_t pattern;
      void'($urandom(32'h9868_0da5));
      test_name   = "reset_state";
      pins_steady = 1'b0;
      reset       = 1'b1;
      usb_addr    = '0;
      usb_wdata   = '0;
      usb_rdn     = 1'b1;
      usb_wrn     = 1'b1;
      usb_cen     = 1'b1;
      usb_alen    = 1'b1;
      target_io   = '0;
      target_nrst = 1'b0;
      rw_addrs = '{`HUSKY_REG_PWR, `HUSKY_REG_TRIG_MASK, `HUSKY_REG_TRIG_MODE,
                   `HUSKY_REG_PIN_BASE, `HUSKY_REG_PIN_BASE + 8'd1, `HUSKY_REG_PIN_BASE + 8'd2};
      model_reset();
      repeat (2) @(posedge clk_usb);
      reset <= 1'b0;
      @(posedge clk_usb);
      pins_steady = 1'b1;

      // Test 1, state after reset
      @(negedge clk_usb);
      check_pins(test_name, '0, '0, pin_val, pin_oe);
      check_power(test_name, 1'b1, power_on);
      check_trigger(test_name, 1'b0, trigger);
      check_data(test_name, 8'h00, usb_rdata);
      if (usb_data_oe !== 1'b0) report_failure("The data bus output enable is set after reset");
      foreach (rw_addrs[i]) begin
         read_reg(rw_addrs[i], rd);
         check_data(test_name, 8'h00, rd);
      end

      // Test 2, write and read back every register
      test_name = "register_rw";
      repeat (2) begin
         foreach (rw_addrs[i]) write_reg(rw_addrs[i], 8'($urandom));
         foreach (rw_addrs[i]) begin
            read_reg(rw_addrs[i], rd);
            check_data(test_name, expected_read(rw_addrs[i], '0), rd);
         end
      end
      read_reg(8'h13, rd);
      check_data(test_name, 8'h00, rd);
      read_reg(8'h17, rd);
      check_data(test_name, 8'h00, rd);
      read_reg({1'b1, 7'($urandom)}, rd);
      check_data(test_name, 8'h00, rd);

      // Test 3, version bytes after one address latch
      test_name = "version_read";
      latch_addr(`HUSKY_REG_VERSION);
      for (int b = 0; b < `HUSKY_VERSION_BYTES; b++) begin
         read_byte(rd);
         check_data(test_name, expected_read(`HUSKY_REG_VERSION, bytecnt_t'(b)), rd);
      end

      // Test 4, pin configurations and target power
      test_name = "pin_control";
      write_reg(`HUSKY_REG_PWR, 8'h00);
      repeat (3) begin
         for (int n = 0; n < `HUSKY_NUM_PINS; n++) begin
            write_reg(reg_addr_t'(`HUSKY_REG_PIN_BASE + n), 8'($urandom));
         end
         @(negedge clk_usb);
         check_pins(test_name, expected_pin_level(), expected_pin_enable(), pin_val, pin_oe);
         write_reg(`HUSKY_REG_PWR, 8'h01);
         @(negedge clk_usb);
         check_pins(test_name, expected_pin_level(), '0, pin_val, pin_oe);
         check_power(test_name, 1'b0, power_on);
         write_reg(`HUSKY_REG_PWR, 8'h00);
         @(negedge clk_usb);
         check_pins(test_name, expected_pin_level(), expected_pin_enable(), pin_val, pin_oe);
         check_power(test_name, 1'b1, power_on);
      end

      // Test 5, trigger combine over random masks and inputs
      test_name = "trigger";
      for (int k = 0; k < TRIG_ROUNDS; k++) begin
         write_reg(`HUSKY_REG_TRIG_MASK, (k == 0) ? 8'h00 : 8'($urandom));
         write_reg(`HUSKY_REG_TRIG_MODE, 8'($urandom));
         repeat (TRIG_PATTERNS) begin
            pattern = trig_mask_t'($urandom);
            @(posedge clk_usb);
            target_io   <= pattern[3:0];
            target_nrst <= pattern[4];
            repeat (4) @(posedge clk_usb);   // Two sync stages and the output register
            @(negedge clk_usb);
            check_trigger(test_name, expected_trigger(pattern), trigger);
         end
      end

      repeat (2) @(posedge clk_usb);
      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

/* src/husky_io_top.sv */
`default_nettype none
`include "husky_settings.svh"

module husky_io_top (
   input  wire                          clk_usb,
   input  wire                          reset_i,
   input  wire husky_pkg::reg_addr_t    usb_addr_i,
   input  wire husky_pkg::reg_data_t    usb_data_i,
   input  wire                          usb_rdn_i,
   input  wire                          usb_wrn_i,
   input  wire                          usb_cen_i,
   input  wire                          usb_alen_i,
   input  wire [3:0]                    target_io_i,
   input  wire                          target_nrst_i,
   output wire husky_pkg::reg_data_t    usb_data_o,
   output wire                          usb_data_oe_o,
   output wire [`HUSKY_NUM_PINS-1:0]    target_pin_o,   // 0 = nRST, 1 = PDID, 2 = PDIC
   output wire [`HUSKY_NUM_PINS-1:0]    target_pin_oe_o,
   output wire                          target_power_on_o,
   output wire                          trigger_o
);
   import husky_pkg::*;

   reg_bus_t                         reg_bus;
   reg_data_t                        rd_data;
   reg_data_t                        rd_ctrl;
   reg_data_t [`HUSKY_NUM_PINS-1:0]  rd_pins;
   logic                             target_highz;

   usb_reg_bridge u_usb_reg_bridge (
      .clk_usb        (clk_usb),
      .reset_i        (reset_i),
      .usb_addr_i     (usb_addr_i),
      .usb_data_i     (usb_data_i),
      .usb_rdn_i      (usb_rdn_i),
      .usb_wrn_i      (usb_wrn_i),
      .usb_cen_i      (usb_cen_i),
      .usb_alen_i     (usb_alen_i),
      .rd_data_i      (rd_data),
      .usb_data_o     (usb_data_o),
      .usb_data_oe_o  (usb_data_oe_o),
      .reg_bus_o      (reg_bus)
   );

   target_ctrl u_target_ctrl (
      .clk_usb            (clk_usb),
      .reset_i            (reset_i),
      .reg_bus_i          (reg_bus),
      .trig_in_i          ({target_nrst_i, target_io_i}),   // nRST on top of io4..io1
      .rd_data_o          (rd_ctrl),
      .target_highz_o     (target_highz),
      .target_power_on_o  (target_power_on_o),
      .trigger_o          (trigger_o)
   );

   for (genvar g = 0; g < `HUSKY_NUM_PINS; g++) begin : gen_pins
      target_pin_ctrl #(
         .PIN_ADDR        (reg_addr_t'(`HUSKY_REG_PIN_BASE + g))
      ) u_target_pin_ctrl (
         .clk_usb         (clk_usb),
         .reset_i         (reset_i),
         .reg_bus_i       (reg_bus),
         .target_highz_i  (target_highz),
         .rd_data_o       (rd_pins[g]),
         .pin_o           (target_pin_o[g]),
         .pin_oe_o        (target_pin_oe_o[g])
      );
   end

   reg_read_mux u_reg_read_mux (
      .clk_usb    (clk_usb),
      .reset_i    (reset_i),
      .reg_bus_i  (reg_bus),
      .rd_ctrl_i  (rd_ctrl),
      .rd_pins_i  (rd_pins),
      .rd_data_o  (rd_data)
   );

endmodule

`default_nettype wire

/* src/reg_read_mux.sv */
`default_nettype none
`include "husky_settings.svh"

module reg_read_mux (
   input  wire                                          clk_usb,
   input  wire                                          reset_i,
   input  wire husky_pkg::reg_bus_t                     reg_bus_i,
   input  wire husky_pkg::reg_data_t                    rd_ctrl_i,
   input  wire husky_pkg::reg_data_t [`HUSKY_NUM_PINS-1:0] rd_pins_i,
   output husky_pkg::reg_data_t                         rd_data_o
);
   import husky_pkg::*;

   localparam logic [31:0] VERSION_WORD = `HUSKY_VERSION_WORD;

   reg_data_t rd_version;
   reg_data_t rd_all;

   // One byte of the version word per read, LSB first
   always_comb begin
      rd_version = '0;
      if (reg_bus_i.rd && reg_bus_i.addr == `HUSKY_REG_VERSION
          && reg_bus_i.bytecnt < `HUSKY_VERSION_BYTES) begin
         rd_version = VERSION_WORD[{reg_bus_i.bytecnt[1:0], 3'b000} +: 8];
      end
   end

   always_comb begin
      rd_all = rd_ctrl_i | rd_version;
      for (int i = 0; i < `HUSKY_NUM_PINS; i++) begin
         rd_all = rd_all | rd_pins_i[i];
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset_i) rd_data_o <= '0;
      else         rd_data_o <= rd_all;
   end

   // Every register owner stays silent outside its read strobe
   a_quiet_without_read: assert property (@(posedge clk_usb) disable iff (reset_i)
      !reg_bus_i.rd |=> (rd_data_o == '0));

endmodule

`default_nettype wire

/* target_io/target_ctrl.sv */
`default_nettype none
`include "husky_settings.svh"

module target_ctrl (
   input  wire                          clk_usb,
   input  wire                          reset_i,
   input  wire husky_pkg::reg_bus_t     reg_bus_i,
   input  wire husky_pkg::trig_mask_t   trig_in_i,
   output husky_pkg::reg_data_t         rd_data_o,
   output logic                         target_highz_o,
   output logic                         target_power_on_o,
   output logic                         trigger_o
);
   import husky_pkg::*;

   logic       pwr_off_q;
   trig_mask_t mask_q;
   trig_mode_t mode_q;
   trig_mask_t sync_q [`HUSKY_SYNC_STAGES];
   trig_mask_t trig_masked;
   logic       trig_any;
   logic       trig_all;

   always_ff @(posedge clk_usb) begin
      if (reset_i) begin
         pwr_off_q <= `HUSKY_PWR_OFF_RST;
         mask_q    <= `HUSKY_TRIG_MASK_RST;
         mode_q    <= TRIG_OR;
      end else if (reg_bus_i.wr) begin
         case (reg_bus_i.addr)
            `HUSKY_REG_PWR:       pwr_off_q <= reg_bus_i.wdata[0];
            `HUSKY_REG_TRIG_MASK: mask_q    <= reg_bus_i.wdata[`HUSKY_NUM_TRIG_IN-1:0];
            `HUSKY_REG_TRIG_MODE: mode_q    <= trig_mode_t'(reg_bus_i.wdata[0]);
            default: ;
         endcase
      end
   end

   // Readback only on our own addresses
   always_comb begin
      rd_data_o = '0;
      if (reg_bus_i.rd) begin
         case (reg_bus_i.addr)
            `HUSKY_REG_PWR:       rd_data_o[0] = pwr_off_q;
            `HUSKY_REG_TRIG_MASK: rd_data_o[`HUSKY_NUM_TRIG_IN-1:0] = mask_q;
            `HUSKY_REG_TRIG_MODE: rd_data_o[0] = mode_q;
            default: ;
         endcase
      end
   end

   assign target_highz_o    = pwr_off_q;
   assign target_power_on_o = !pwr_off_q;

   // Target I/O is asynchronous to clk_usb
   always_ff @(posedge clk_usb) begin
      if (reset_i) begin
         for (int i = 0; i < `HUSKY_SYNC_STAGES; i++) begin
            sync_q[i] <= '0;
         end
         trigger_o <= 1'b0;
      end else begin
         sync_q[0] <= trig_in_i;
         for (int i = 1; i < `HUSKY_SYNC_STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
         trigger_o <= (mode_q == TRIG_AND) ? trig_all : trig_any;
      end
   end

   assign trig_masked = sync_q[`HUSKY_SYNC_STAGES-1] & mask_q;
   assign trig_any    = |trig_masked;
   assign trig_all    = (trig_masked == mask_q) && (|mask_q);   // Empty mask never fires

endmodule

`default_nettype wire

/* target_io/target_pin_ctrl.sv */
`default_nettype none

module target_pin_ctrl #(
   parameter husky_pkg::reg_addr_t PIN_ADDR = 8'h00
) (
   input  wire                        clk_usb,
   input  wire                        reset_i,
   input  wire husky_pkg::reg_bus_t   reg_bus_i,
   input  wire                        target_highz_i,
   output husky_pkg::reg_data_t       rd_data_o,
   output logic                       pin_o,
   output logic                       pin_oe_o
);
   import husky_pkg::*;

   pin_cfg_t cfg_q;
   logic     hit;

   assign hit = (reg_bus_i.addr == PIN_ADDR);

   always_ff @(posedge clk_usb) begin
      if (reset_i) begin
         cfg_q <= '0;   // Pin floats
      end else if (reg_bus_i.wr && hit) begin
         cfg_q <= pin_cfg_t'(reg_bus_i.wdata[1:0]);
      end
   end

   always_comb begin
      rd_data_o = '0;
      if (reg_bus_i.rd && hit) rd_data_o[1:0] = cfg_q;
   end

   assign pin_o    = cfg_q.level;
   assign pin_oe_o = cfg_q.enable && !target_highz_i;   // Never drive an unpowered target

   // A pin starts driving only after its own write or when target power comes back
   a_no_drive_unpowered: assert property (@(posedge clk_usb) disable iff (reset_i)
      $rose(pin_oe_o) |-> ($past(reg_bus_i.wr && hit) || $fell(target_highz_i)));

endmodule

`default_nettype wire

/* src/usb_reg_bridge.sv */
`default_nettype none

module usb_reg_bridge (
   input  wire                        clk_usb,
   input  wire                        reset_i,
   input  wire husky_pkg::reg_addr_t  usb_addr_i,
   input  wire husky_pkg::reg_data_t  usb_data_i,
   input  wire                        usb_rdn_i,
   input  wire                        usb_wrn_i,
   input  wire                        usb_cen_i,
   input  wire                        usb_alen_i,
   input  wire husky_pkg::reg_data_t  rd_data_i,
   output husky_pkg::reg_data_t       usb_data_o,
   output logic                       usb_data_oe_o,
   output husky_pkg::reg_bus_t        reg_bus_o
);
   import husky_pkg::*;

   bus_state_t state_q;
   logic       rdn_q;
   logic       wrn_q;
   logic       cen_q;
   logic       wr_start;
   logic       rd_start;
   reg_addr_t  addr_q;
   bytecnt_t   bytecnt_q;
   reg_data_t  wdata_q;
   logic       rd_stb_q;
   logic       wr_stb_q;
   logic       rd_cap_q;   // Mux output holds the read byte
   reg_data_t  rdata_q;

   // Host strobes are sampled once before the FSM looks at them
   always_ff @(posedge clk_usb) begin
      if (reset_i) begin
         rdn_q <= 1'b1;
         wrn_q <= 1'b1;
         cen_q <= 1'b1;
      end else begin
         rdn_q <= usb_rdn_i;
         wrn_q <= usb_wrn_i;
         cen_q <= usb_cen_i;
      end
   end

   assign wr_start = (state_q == IDLE) && !cen_q && !wrn_q;
   assign rd_start = (state_q == IDLE) && !cen_q && !rdn_q;

   always_ff @(posedge clk_usb) begin
      if (reset_i) begin
         state_q       <= IDLE;
         wr_stb_q      <= 1'b0;
         rd_stb_q      <= 1'b0;
         usb_data_oe_o <= 1'b0;
      end else begin
         wr_stb_q <= wr_start;
         rd_stb_q <= rd_start;
         case (state_q)
            IDLE: begin
               if (wr_start) begin
                  state_q <= WRITE_HELD;
               end else if (rd_start) begin
                  state_q       <= READ_HELD;
                  usb_data_oe_o <= 1'b1;
               end
            end
            WRITE_HELD: begin
               if (wrn_q) state_q <= IDLE;   // Wait for WRn to go back high
            end
            READ_HELD: begin
               if (rdn_q) begin
                  state_q       <= IDLE;
                  usb_data_oe_o <= 1'b0;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Write data comes off the bus when the access starts
   always_ff @(posedge clk_usb) begin
      if (wr_start) wdata_q <= usb_data_i;
   end

   // ALEn restarts the byte count, each strobe advances it
   always_ff @(posedge clk_usb) begin
      if (reset_i) begin
         addr_q    <= '0;
         bytecnt_q <= '0;
      end else if (!usb_alen_i) begin
         addr_q    <= usb_addr_i;
         bytecnt_q <= '0;
      end else if (rd_stb_q || wr_stb_q) begin
         bytecnt_q <= bytecnt_q + 1'b1;
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset_i) begin
         rd_cap_q <= 1'b0;
         rdata_q  <= '0;
      end else begin
         rd_cap_q <= rd_stb_q;
         if (rd_cap_q) rdata_q <= rd_data_i;
      end
   end

   // Straight from the mux in the first valid cycle, then from the hold register
   assign usb_data_o = rd_cap_q ? rd_data_i : rdata_q;

   always_comb begin
      reg_bus_o.addr    = addr_q;
      reg_bus_o.bytecnt = bytecnt_q;
      reg_bus_o.wdata   = wdata_q;
      reg_bus_o.rd      = rd_stb_q;
      reg_bus_o.wr      = wr_stb_q;
   end

   a_strobe_excl: assert property (@(posedge clk_usb) disable iff (reset_i)
      !(rd_stb_q && wr_stb_q));

endmodule

`default_nettype wire

/* common/husky_pkg.sv */
`default_nettype none
`include "husky_settings.svh"

package husky_pkg;

   typedef logic [7:0] reg_addr_t;
   typedef logic [7:0] reg_data_t;

   // Byte index inside a multi-byte access
   typedef logic [`HUSKY_BYTECNT_BITS-1:0] bytecnt_t;

   // Bit 0..3 = io1..io4, bit 4 = nRST
   typedef logic [`HUSKY_NUM_TRIG_IN-1:0] trig_mask_t;

   // Internal register bus, strobes are one cycle wide
   typedef struct packed {
      reg_addr_t addr;
      bytecnt_t  bytecnt;
      reg_data_t wdata;
      logic      rd;
      logic      wr;
   } reg_bus_t;

   // Stored in bits 1:0 of a pin register
   typedef struct packed {
      logic level;    // Bit 1
      logic enable;   // Bit 0
   } pin_cfg_t;

   typedef enum logic [1:0] {
      IDLE,
      WRITE_HELD,
      READ_HELD
   } bus_state_t;

   typedef enum logic {
      TRIG_OR  = 1'b0,
      TRIG_AND = 1'b1
   } trig_mode_t;

endpackage

`default_nettype wire

/* common/husky_settings.svh */
`ifndef HUSKY_SETTINGS_SVH
`define HUSKY_SETTINGS_SVH

// Register map of the host bus
`define HUSKY_REG_PWR         8'h10   // Bit 0 set powers the target off
`define HUSKY_REG_TRIG_MASK   8'h11   // One bit per trigger input
`define HUSKY_REG_TRIG_MODE   8'h12   // Bit 0 selects AND combine
`define HUSKY_REG_PIN_BASE    8'h14   // nRST, PDID, PDIC follow in order
`define HUSKY_REG_VERSION     8'h20   // Read by byte count

// Version word, least-significant byte goes out first
`define HUSKY_VERSION_WORD    32'h4855_0102
`define HUSKY_VERSION_BYTES   4

// Sizes
`define HUSKY_NUM_PINS        3
`define HUSKY_NUM_TRIG_IN     5
`define HUSKY_BYTECNT_BITS    7
`define HUSKY_SYNC_STAGES     2

// Values after reset
`define HUSKY_PWR_OFF_RST     1'b0    // Target powered
`define HUSKY_TRIG_MASK_RST   5'h00

`endif
